//--- design/bus_cfg.svh
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 64

// data ram, four byte lanes of RAM_WORDS entries each
`define LANES 4
`define RAM_BASE 32'h0000_1000
`define RAM_WORDS 1024
`define RAM_BYTES (`RAM_WORDS * 4)
`define RAM_IDX_W 10 // log2 of RAM_WORDS

// keyboard
`define KEY_ADDR 32'h0000_8000

// sd card registers
`define SDC_ADDR_REG 32'h0000_8010  // sector address, write only
`define SDC_READ_REG 32'h0000_8018  // any write starts a sector read
`define SDC_READY_REG 32'h0000_8020 // controller idle
`define SDC_AVAIL_REG 32'h0000_8028 // sector buffer full

// sd sector buffer window
`define SDC_BUF_BASE 32'h0000_9000
`define SDC_BUF_BYTES 512
`define SDC_BUF_IDX_W 9 // log2 of SDC_BUF_BYTES

`endif

//--- design/bus_fabric_top.sv
`include "bus_cfg.svh"

module bus_fabric_top import bus_pkg::*; (
    input  logic               CLOCK_50,
    input  logic               KEY0,            // async reset, low active
    // core bus
    input  logic [`ADDR_W-1:0] bus_address,
    input  logic [`DATA_W-1:0] bus_write_data,
    input  logic               bus_read_enable, // one-cycle strobes
    input  logic               bus_write_enable,
    input  load_op_e           bus_read_type,
    input  store_op_e          bus_write_type,
    output logic [`DATA_W-1:0] bus_read_data,
    output logic               bus_done,
    // keyboard
    input  logic               key_strobe,
    input  logic [7:0]         key_ascii,
    input  logic               irq_ack,
    output logic [3:0]         irq_vector,
    // sd card
    input  logic               sd_ready,
    input  logic               sd_byte_strobe,
    input  logic [7:0]         sd_byte,
    output logic [31:0]        sd_sector_addr,
    output logic               sd_read_start
);

    lane_req_if lreq ();
    periph_if   pif ();

    beat_tag_t  beat_tag;               // decoder to aligner
    logic [7:0] lane_rdata [`LANES];    // lane 0 is the low byte

    bus_request_decoder u_dec (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_type    (bus_read_type),
        .bus_write_type   (bus_write_type),
        .lreq             (lreq),
        .pif              (pif),
        .tag              (beat_tag)
    );

    for (genvar i = 0; i < `LANES; i++) begin : g_lane
        ram_byte_lane #(.lane_id(i)) u_lane (
            .CLOCK_50 (CLOCK_50),
            .lreq     (lreq),
            .rdata    (lane_rdata[i])
        );
    end

    load_aligner u_align (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .tag           (beat_tag),
        .lane_rdata    (lane_rdata),
        .key_rdata     (pif.key_rdata),
        .sd_rdata      (pif.sd_rdata),
        .bus_read_data (bus_read_data),
        .bus_done      (bus_done)
    );

    key_irq_ctrl u_key (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .pif        (pif),
        .key_strobe (key_strobe),
        .key_ascii  (key_ascii),
        .irq_ack    (irq_ack),
        .irq_vector (irq_vector)
    );

    sd_sector_buffer u_sd (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .pif            (pif),
        .sd_ready       (sd_ready),
        .sd_byte_strobe (sd_byte_strobe),
        .sd_byte        (sd_byte),
        .sd_sector_addr (sd_sector_addr),
        .sd_read_start  (sd_read_start)
    );

endmodule

//--- design/bus_if.sv
`include "bus_cfg.svh"

// one beat towards the ram lanes, each lane picks its own byte
interface lane_req_if;
    logic                  en;         // lane access this beat
    logic                  we;
    logic [`RAM_IDX_W-1:0] word_index;
    logic [7:0]            wbyte [`LANES]; // store data already steered
    logic [`LANES-1:0]     be;

    modport master (
        output en, we, word_index, wbyte, be
    );

    modport lane (
        input en, we, word_index, wbyte, be
    );
endinterface

// register side, shared by keyboard and sd block
interface periph_if import bus_pkg::*; ();
    region_e                  region;
    logic                     rd;         // strobes, qualified by region in each device
    logic                     wr;
    logic [31:0]              wdata;      // low word of the store
    logic [`SDC_BUF_IDX_W-1:0] buf_offset;
    logic [7:0]               key_rdata;  // one edge after rd
    logic [7:0]               sd_rdata;

    modport master (
        output region, rd, wr, wdata, buf_offset,
        input  key_rdata, sd_rdata
    );

    modport dev (
        input  region, rd, wr, wdata, buf_offset,
        output key_rdata, sd_rdata
    );
endinterface

//--- design/bus_pkg.sv
package bus_pkg;

    // address region, decided once per request
    typedef enum logic [2:0] {
        REG_NONE      = 3'd0, // unmapped, reads give zero
        REG_RAM       = 3'd1,
        REG_KEY       = 3'd2,
        REG_SDC_ADDR  = 3'd3,
        REG_SDC_READ  = 3'd4,
        REG_SDC_READY = 3'd5,
        REG_SDC_AVAIL = 3'd6,
        REG_SDC_BUF   = 3'd7
    } region_e;

    // load types as the core encodes them, bit 2 means unsigned
    typedef enum logic [2:0] {
        LD_B  = 3'd0,
        LD_H  = 3'd1,
        LD_W  = 3'd2,
        LD_D  = 3'd3,
        LD_BU = 3'd4,
        LD_HU = 3'd5,
        LD_WU = 3'd6
    } load_op_e;

    typedef enum logic [2:0] {
        ST_B = 3'd0,
        ST_H = 3'd1,
        ST_W = 3'd2,
        ST_D = 3'd3
    } store_op_e;

    // follows each beat from decoder to aligner
    typedef struct packed {
        logic     valid;
        logic     is_read;
        region_e  region;
        load_op_e load_op;
        logic [1:0] offset; // byte offset inside the word
        logic     last;     // done is raised on this beat
    } beat_tag_t;

endpackage

//--- design/bus_request_decoder.sv
`include "bus_cfg.svh"

module bus_request_decoder import bus_pkg::*; (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  logic [`ADDR_W-1:0] bus_address,
    input  logic [`DATA_W-1:0] bus_write_data,
    input  logic               bus_read_enable,
    input  logic               bus_write_enable,
    input  load_op_e           bus_read_type,
    input  store_op_e          bus_write_type,
    lane_req_if.master         lreq,
    periph_if.master           pif,
    output beat_tag_t          tag
);

    region_e               region;
    logic [1:0]            offset;    // aligned byte offset
    logic [`ADDR_W-1:0]    ram_rel;
    logic [`ADDR_W-1:0]    buf_rel;
    logic [`LANES*8-1:0]   lane_word; // store word after steering
    logic [`LANES-1:0]     be;
    logic                  req;
    logic                  dword;
    logic                  beat2;     // second word of a doubleword pending
    logic [`DATA_W/2-1:0]  hi_word;   // upper half kept for beat 1

    assign req   = bus_read_enable | bus_write_enable;
    assign dword = bus_read_enable ? (bus_read_type == LD_D) : (bus_write_type == ST_D);

    assign ram_rel = bus_address - `RAM_BASE;
    assign buf_rel = bus_address - `SDC_BUF_BASE;

    // address map
    always_comb begin
        region = REG_NONE;
        if (bus_address >= `RAM_BASE && bus_address < `RAM_BASE + `RAM_BYTES)
            region = REG_RAM;
        else if (bus_address == `KEY_ADDR)
            region = REG_KEY;
        else if (bus_address == `SDC_ADDR_REG)
            region = REG_SDC_ADDR;
        else if (bus_address == `SDC_READ_REG)
            region = REG_SDC_READ;
        else if (bus_address == `SDC_READY_REG)
            region = REG_SDC_READY;
        else if (bus_address == `SDC_AVAIL_REG)
            region = REG_SDC_AVAIL;
        else if (bus_address >= `SDC_BUF_BASE && bus_address < `SDC_BUF_BASE + `SDC_BUF_BYTES)
            region = REG_SDC_BUF;
    end

    // halves drop bit 0, words and doublewords sit on the word boundary
    always_comb begin
        if (bus_read_enable) begin
            case (bus_read_type)
                LD_B, LD_BU: offset = bus_address[1:0];
                LD_H, LD_HU: offset = {bus_address[1], 1'b0};
                default:     offset = 2'd0;
            endcase
        end else begin
            case (bus_write_type)
                ST_B:    offset = bus_address[1:0];
                ST_H:    offset = {bus_address[1], 1'b0};
                default: offset = 2'd0;
            endcase
        end
    end

    // store steering onto lanes
    always_comb begin
        case (bus_write_type)
            ST_B:    be = `LANES'(1) << offset;
            ST_H:    be = `LANES'(3) << offset;
            default: be = '1; // word, and each doubleword beat
        endcase
        lane_word = bus_write_data[`LANES*8-1:0] << {offset, 3'b000};
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            lreq.en <= 1'b0;
            lreq.we <= 1'b0;
            pif.rd  <= 1'b0;
            pif.wr  <= 1'b0;
            tag     <= '0;
            beat2   <= 1'b0;
        end else if (beat2) begin
            lreq.en  <= (tag.region == REG_RAM); // we held from beat 0
            pif.rd   <= 1'b0; // devices see beat 0 only
            pif.wr   <= 1'b0;
            tag.last <= 1'b1;
            beat2    <= 1'b0;
        end else begin
            lreq.en       <= req && (region == REG_RAM);
            lreq.we       <= bus_write_enable;
            pif.rd        <= bus_read_enable;
            pif.wr        <= bus_write_enable;
            tag.valid     <= req;
            tag.is_read   <= bus_read_enable;
            tag.region    <= region;
            tag.load_op   <= bus_read_type;
            tag.offset    <= offset;
            tag.last      <= !dword;
            beat2         <= req && dword;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (beat2) begin
            lreq.word_index <= lreq.word_index + 1'b1; // next word
            for (int i = 0; i < `LANES; i++)
                lreq.wbyte[i] <= hi_word[8*i +: 8];
            lreq.be <= '1;
        end else begin
            lreq.word_index <= ram_rel[`RAM_IDX_W+1:2];
            for (int i = 0; i < `LANES; i++)
                lreq.wbyte[i] <= lane_word[8*i +: 8];
            lreq.be        <= be;
            pif.region     <= region;
            pif.wdata      <= bus_write_data[31:0];
            pif.buf_offset <= buf_rel[`SDC_BUF_IDX_W-1:0];
            hi_word        <= bus_write_data[`DATA_W-1:`DATA_W/2];
        end
    end

endmodule

//--- design/key_irq_ctrl.sv
module key_irq_ctrl import bus_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    periph_if.dev      pif,
    input  logic       key_strobe, // one cycle per key press
    input  logic [7:0] key_ascii,
    input  logic       irq_ack,
    output logic [3:0] irq_vector
);

    logic [7:0] ascii_q; // last key seen
    logic       key_hit;

    assign key_hit = key_strobe && (key_ascii != 8'h00);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ascii_q       <= 8'h00;
            irq_vector    <= 4'd0;
            pif.key_rdata <= 8'h00;
        end else begin
            if (key_strobe)
                ascii_q <= key_ascii;
            // keyboard is vector 1
            if (key_hit)
                irq_vector <= 4'd1;
            // ack wins over a new key in the same cycle
            if (irq_vector != 4'd0 && irq_ack)
                irq_vector <= 4'd0;
            // zero unless this is a KEY read
            pif.key_rdata <= (pif.rd && pif.region == REG_KEY) ? ascii_q : 8'h00;
        end
    end

endmodule

//--- design/load_aligner.sv
`include "bus_cfg.svh"

module load_aligner import bus_pkg::*; (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  beat_tag_t          tag,
    input  logic [7:0]         lane_rdata [`LANES],
    input  logic [7:0]         key_rdata,
    input  logic [7:0]         sd_rdata,
    output logic [`DATA_W-1:0] bus_read_data,
    output logic               bus_done
);

    beat_tag_t           tag_q;     // lines up with lane rdata
    logic [`LANES*8-1:0] lane_word;
    logic [31:0]         beat_word;
    logic [31:0]         shifted;
    logic [31:0]         lo_word;   // beat 0 of a doubleword
    logic [`DATA_W-1:0]  result;

    always_comb begin
        for (int i = 0; i < `LANES; i++)
            lane_word[8*i +: 8] = lane_rdata[i]; // little endian
        case (tag_q.region)
            REG_RAM:       beat_word = lane_word;
            REG_KEY:       beat_word = {24'd0, key_rdata};
            REG_SDC_READY,
            REG_SDC_AVAIL,
            REG_SDC_BUF:   beat_word = {24'd0, sd_rdata};
            default:       beat_word = 32'd0; // unmapped and write-only regs
        endcase
        shifted = beat_word >> {tag_q.offset, 3'b000};
    end

    // extension by load type
    always_comb begin
        if (tag_q.load_op == LD_D) begin
            result = {beat_word, lo_word};
        end else if (tag_q.region != REG_RAM) begin
            result = {32'd0, beat_word}; // device values are unsigned
        end else begin
            case (tag_q.load_op)
                LD_B:    result = {{56{shifted[7]}}, shifted[7:0]};
                LD_H:    result = {{48{shifted[15]}}, shifted[15:0]};
                LD_W:    result = {{32{shifted[31]}}, shifted};
                LD_BU:   result = {56'd0, shifted[7:0]};
                LD_HU:   result = {48'd0, shifted[15:0]};
                default: result = {32'd0, shifted}; // LD_WU
            endcase
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            tag_q    <= '0;
            bus_done <= 1'b0;
        end else begin
            tag_q    <= tag;
            bus_done <= tag_q.valid && tag_q.last; // one pulse per access
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (tag_q.valid && !tag_q.last)
            lo_word <= beat_word;
        if (tag_q.valid && tag_q.last && tag_q.is_read)
            bus_read_data <= result; // held until the next read
    end

endmodule

//--- design/ram_byte_lane.sv
`include "bus_cfg.svh"

module ram_byte_lane #(
    parameter int lane_id = 0 // byte position in the word
) (
    input  logic       CLOCK_50,
    lane_req_if.lane   lreq,
    output logic [7:0] rdata
);

    logic [7:0] mem [`RAM_WORDS];
    logic       wr_hit;

    assign wr_hit = lreq.en && lreq.we && lreq.be[lane_id];

    // read happens on every enabled beat, old data on a write
    always_ff @(posedge CLOCK_50) begin
        if (wr_hit)
            mem[lreq.word_index] <= lreq.wbyte[lane_id];
        if (lreq.en)
            rdata <= mem[lreq.word_index];
    end

endmodule

//--- design/sd_sector_buffer.sv
`include "bus_cfg.svh"

module sd_sector_buffer import bus_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    periph_if.dev       pif,
    input  logic        sd_ready,       // controller idle
    input  logic        sd_byte_strobe, // one cycle per received byte
    input  logic [7:0]  sd_byte,
    output logic [31:0] sd_sector_addr,
    output logic        sd_read_start
);

    logic [7:0]                sector_buf [`SDC_BUF_BYTES];
    logic [`SDC_BUF_IDX_W-1:0] fill_idx; // wraps after the last byte
    logic                      avail;
    logic                      start_hit;
    logic                      byte_hit;

    assign start_hit = pif.wr && (pif.region == REG_SDC_READ);
    assign byte_hit  = sd_byte_strobe && !start_hit; // a new read restarts the fill

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_sector_addr <= 32'd0;
            sd_read_start  <= 1'b0;
            avail          <= 1'b0;
            fill_idx       <= '0;
        end else begin
            sd_read_start <= start_hit; // single cycle
            if (pif.wr && pif.region == REG_SDC_ADDR)
                sd_sector_addr <= pif.wdata;
            if (start_hit) begin
                avail    <= 1'b0;
                fill_idx <= '0;
            end else if (byte_hit) begin
                fill_idx <= fill_idx + 1'b1;
                if (fill_idx == '1)
                    avail <= 1'b1; // whole sector in
            end
        end
    end

    // buffer and register reads
    always_ff @(posedge CLOCK_50) begin
        if (byte_hit)
            sector_buf[fill_idx] <= sd_byte;
        if (pif.rd) begin
            case (pif.region)
                REG_SDC_READY: pif.sd_rdata <= {7'd0, sd_ready};
                REG_SDC_AVAIL: pif.sd_rdata <= {7'd0, avail};
                REG_SDC_BUF:   pif.sd_rdata <= sector_buf[pif.buf_offset];
                default:       pif.sd_rdata <= 8'h00;
            endcase
        end else begin
            pif.sd_rdata <= 8'h00; // idle value, aligner only looks on reads
        end
    end

endmodule

//--- files.f
+incdir+design
design/bus_pkg.sv
design/bus_if.sv
design/ram_byte_lane.sv
design/bus_request_decoder.sv
design/load_aligner.sv
design/key_irq_ctrl.sv
design/sd_sector_buffer.sv
design/bus_fabric_top.sv
test/bus_fabric_chk.sv
test/tb_bus_fabric.sv

//--- run.sh
#!/bin/sh
# build and run the bus fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_bus_fabric -o sim_bus || exit 1

out=$(./obj_dir/sim_bus)
echo "$out"
echo "$out" | grep -qx "Regression passed" && exit 0 || exit 1

//--- test/bus_fabric_chk.sv
`include "bus_cfg.svh"

module bus_fabric_chk import bus_pkg::*; (
    input logic               CLOCK_50,
    input logic               KEY0,
    input logic [`ADDR_W-1:0] bus_address,
    input logic               bus_read_enable,
    input logic               bus_write_enable,
    input load_op_e           bus_read_type,
    input store_op_e          bus_write_type,
    input logic               bus_done,
    input logic [3:0]         irq_vector,
    input logic               sd_read_start,
    input logic               lane_en,    // decoder beat towards the lanes
    input logic               lane_we
);
    timeunit 1ns;
    timeprecision 1ps;

    logic req;
    logic req_single; // one-beat access
    logic in_ram;     // request address inside the 4 KiB ram window

    assign req        = bus_read_enable | bus_write_enable;
    assign req_single = bus_read_enable ? (bus_read_type != LD_D)
                                        : (bus_write_enable && bus_write_type != ST_D);
    assign in_ram     = (bus_address >= `RAM_BASE) && (bus_address < `RAM_BASE + `RAM_BYTES);

    // lone single-beat request gives one done pulse
    a_done_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (req_single ##1 !req) |=> ##1 bus_done ##1 !bus_done)
        else $error("bus_done not a single pulse");

    a_irq_range: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        irq_vector <= 4'd1)
        else $error("irq_vector out of range");

    a_start_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_read_start |=> !sd_read_start)
        else $error("sd_read_start longer than one cycle");

    // beat 0 comes from the request one edge back, beat 1 from two edges back
    a_lane_region: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (lane_en && lane_we) |-> ($past(req) ? $past(in_ram) : $past(in_ram, 2)))
        else $error("lane write outside ram");

endmodule

bind bus_fabric_top bus_fabric_chk u_chk (
    .CLOCK_50         (CLOCK_50),
    .KEY0             (KEY0),
    .bus_address      (bus_address),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable),
    .bus_read_type    (bus_read_type),
    .bus_write_type   (bus_write_type),
    .bus_done         (bus_done),
    .irq_vector       (irq_vector),
    .sd_read_start    (sd_read_start),
    .lane_en          (lreq.en),
    .lane_we          (lreq.we)
);

//--- test/bus_golden.txt
# test kind addr type data expected, hex for addr, data and expected
# kind 0 write 1 read 2 key 3 ack 4 sd fill 5 irq 6 sd_ready 7 read pair 8 sd buf 9 sector
1 0 00001000 2 0000000087654321 0000000000000000
2 1 00001000 2 0000000000000000 ffffffff87654321
3 1 00001000 6 0000000000000000 0000000087654321
4 1 00001001 0 0000000000000000 0000000000000043
5 1 00001003 0 0000000000000000 ffffffffffffff87
6 1 00001003 4 0000000000000000 0000000000000087
7 1 00001002 1 0000000000000000 ffffffffffff8765
8 1 00001002 5 0000000000000000 0000000000008765
9 0 00001005 0 00000000000000ab 0000000000000000
10 1 00001005 4 0000000000000000 00000000000000ab
11 0 00001006 1 000000000000cdef 0000000000000000
12 1 00001006 5 0000000000000000 000000000000cdef
13 0 00001004 0 0000000000000012 0000000000000000
14 1 00001004 2 0000000000000000 ffffffffcdefab12
15 0 00001010 3 0123456789abcdef 0000000000000000
16 1 00001010 3 0000000000000000 0123456789abcdef
17 1 00001014 2 0000000000000000 0000000001234567
18 1 00001010 6 0000000000000000 0000000089abcdef
19 7 00001000 2 ffffffffcdefab12 ffffffff87654321
20 2 00000000 0 0000000000000041 0000000000000000
21 5 00000000 0 0000000000000000 0000000000000001
22 1 00008000 4 0000000000000000 0000000000000041
23 3 00000000 0 0000000000000000 0000000000000000
24 5 00000000 0 0000000000000000 0000000000000000
25 2 00000000 0 0000000000000000 0000000000000000
26 5 00000000 0 0000000000000000 0000000000000000
27 0 00008010 2 0000000000000abc 0000000000000000
28 9 00000000 0 0000000000000000 0000000000000abc
29 0 00008018 2 0000000000000000 0000000000000000
30 1 00008028 6 0000000000000000 0000000000000000
31 4 00000000 0 0000000000000000 0000000000000000
32 1 00008028 6 0000000000000000 0000000000000001
33 8 00009000 4 0000000000000000 0000000000000000
34 8 00009001 4 0000000000000000 0000000000000000
35 8 00009100 4 0000000000000000 0000000000000000
36 8 000091ff 4 0000000000000000 0000000000000000
37 6 00000000 0 0000000000000001 0000000000000000
38 1 00008020 6 0000000000000000 0000000000000001
39 6 00000000 0 0000000000000000 0000000000000000
40 1 00008020 6 0000000000000000 0000000000000000
41 0 00004000 2 00000000deadbeef 0000000000000000
42 1 00004000 2 0000000000000000 0000000000000000
43 1 00001000 6 0000000000000000 0000000087654321

//--- test/tb_bus_fabric.sv
`include "bus_cfg.svh"

module tb_bus_fabric import bus_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic               CLOCK_50;
    logic               KEY0;
    logic [`ADDR_W-1:0] bus_address;
    logic [`DATA_W-1:0] bus_write_data;
    logic               bus_read_enable;
    logic               bus_write_enable;
    load_op_e           bus_read_type;
    store_op_e          bus_write_type;
    logic [`DATA_W-1:0] bus_read_data;
    logic               bus_done;
    logic               key_strobe;
    logic [7:0]         key_ascii;
    logic               irq_ack;
    logic [3:0]         irq_vector;
    logic               sd_ready;
    logic               sd_byte_strobe;
    logic [7:0]         sd_byte;
    logic [31:0]        sd_sector_addr;
    logic               sd_read_start;

    // golden file columns
    int          q_num [$];
    int          q_kind [$];
    logic [31:0] q_addr [$];
    int          q_type [$];
    logic [63:0] q_data [$];
    logic [63:0] q_exp [$];

    logic [7:0]  sd_copy [`SDC_BUF_BYTES]; // bytes sent into the sector buffer
    int          errors = 0;
    int          passed = 0;
    int          cycles = 0;
    int          limit = 0;  // 0 until the golden file is loaded
    integer      seed = 90890;

    bus_fabric_top dut (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50; // 100 ns
    end

    // run limit
    initial begin
        forever begin
            @(posedge CLOCK_50);
            cycles++;
            if (limit != 0 && cycles > limit) begin
                $display("run timed out after %0d cycles", cycles);
                $display("Regression failed");
                $finish;
            end
        end
    end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic idle_bus();
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
    endtask

    task automatic issue(input logic rd, input logic [31:0] addr, input int typ,
                         input logic [63:0] data);
        bus_address      = addr;
        bus_write_data   = data;
        bus_read_enable  = rd;
        bus_write_enable = !rd;
        if (rd)
            bus_read_type = load_op_e'(typ);
        else
            bus_write_type = store_op_e'(typ);
    endtask

    // counts edges after the sampling edge until done
    task automatic wait_done(inout int lat, inout int starts);
        while (!bus_done && lat < 10) begin
            @(negedge CLOCK_50);
            lat++;
            if (sd_read_start)
                starts++;
        end
        if (!bus_done) begin
            $display("bus_done never came, at %0t", $time);
            errors++;
        end
    endtask

    task automatic access(input logic rd, input logic [31:0] addr, input int typ,
                          input logic [63:0] data, output logic [63:0] rdata);
        int lat;
        int starts;
        int exp_lat;
        lat = 0;
        starts = 0;
        exp_lat = (typ == 3) ? 3 : 2; // LD_D and ST_D share code 3
        issue(rd, addr, typ, data);
        @(negedge CLOCK_50);
        idle_bus();
        wait_done(lat, starts);
        rdata = bus_read_data;
        check_val("bus_done latency", 64'(lat), 64'(exp_lat));
        if (!rd)
            check_val("sd_read_start pulses", 64'(starts),
                      (addr == `SDC_READ_REG) ? 64'd1 : 64'd0);
    endtask

    task automatic read_pair(input logic [31:0] addr, input int typ,
                             input logic [63:0] exp_a, input logic [63:0] exp_b);
        int lat;
        int starts;
        lat = 0;
        starts = 0;
        issue(1'b1, addr, typ, 64'd0);
        @(negedge CLOCK_50);
        issue(1'b1, addr + 32'd4, typ, 64'd0); // second request right behind
        @(negedge CLOCK_50);
        idle_bus();
        lat = 1;
        wait_done(lat, starts);
        check_val("bus_done latency", 64'(lat), 64'd2);
        check_val("bus_read_data", bus_read_data, exp_a);
        @(negedge CLOCK_50);
        check_val("bus_done", 64'(bus_done), 64'd1);
        check_val("bus_read_data", bus_read_data, exp_b);
    endtask

    task automatic fill_sector();
        integer r;
        for (int i = 0; i < `SDC_BUF_BYTES; i++) begin
            r = $random(seed);
            sd_byte_strobe = 1'b1;
            sd_byte        = r[7:0];
            sd_copy[i]     = r[7:0];
            @(negedge CLOCK_50);
        end
        sd_byte_strobe = 1'b0;
        @(negedge CLOCK_50);
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        int          num;
        int          kind;
        int          typ;
        logic [31:0] addr;
        logic [63:0] data;
        logic [63:0] exp;
        string       line;
        fd = $fopen("test/bus_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open test/bus_golden.txt");
            $display("Regression failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %h %d %h %h", num, kind, addr, typ, data, exp);
                    if (n == 6) begin
                        q_num.push_back(num);
                        q_kind.push_back(kind);
                        q_addr.push_back(addr);
                        q_type.push_back(typ);
                        q_data.push_back(data);
                        q_exp.push_back(exp);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        logic [63:0] rdata;
        int          err_before;
        KEY0 = 1'b0;
        bus_address = '0;
        bus_write_data = '0;
        bus_read_enable = 1'b0;
        bus_write_enable = 1'b0;
        bus_read_type = LD_B;
        bus_write_type = ST_B;
        key_strobe = 1'b0;
        key_ascii = 8'h00;
        irq_ack = 1'b0;
        sd_ready = 1'b0;
        sd_byte_strobe = 1'b0;
        sd_byte = 8'h00;
        load_golden();
        limit = q_num.size() * 10 + 2 * `SDC_BUF_BYTES * 2 + 100;
        repeat (8) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);

        foreach (q_num[t]) begin
            err_before = errors;
            case (q_kind[t])
                0: access(1'b0, q_addr[t], q_type[t], q_data[t], rdata);
                1: begin
                    access(1'b1, q_addr[t], q_type[t], 64'd0, rdata);
                    check_val("bus_read_data", rdata, q_exp[t]);
                end
                2: begin
                    key_strobe = 1'b1;
                    key_ascii  = q_data[t][7:0];
                    @(negedge CLOCK_50);
                    key_strobe = 1'b0;
                    @(negedge CLOCK_50);
                end
                3: begin
                    irq_ack = 1'b1;
                    @(negedge CLOCK_50);
                    irq_ack = 1'b0;
                    @(negedge CLOCK_50);
                end
                4: fill_sector();
                5: check_val("irq_vector", 64'(irq_vector), q_exp[t]);
                6: begin
                    sd_ready = q_data[t][0];
                    @(negedge CLOCK_50);
                end
                7: read_pair(q_addr[t], q_type[t], q_exp[t], q_data[t]);
                8: begin
                    access(1'b1, q_addr[t], q_type[t], 64'd0, rdata);
                    check_val("bus_read_data", rdata,
                              64'(sd_copy[q_addr[t] - `SDC_BUF_BASE]));
                end
                9: check_val("sd_sector_addr", 64'(sd_sector_addr), q_exp[t]);
                default: begin
                    $display("test %0d has an unknown kind %0d", q_num[t], q_kind[t]);
                    errors++;
                end
            endcase
            if (errors == err_before) begin
                passed++;
                $display("test %0d kind %0d ok", q_num[t], q_kind[t]);
            end else begin
                $display("test %0d kind %0d FAILED", q_num[t], q_kind[t]);
            end
        end

        $display("%0d tests, %0d passed, %0d errors", q_num.size(), passed, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
